//--- logic/selfcheck_pkg.sv
package selfcheck_pkg;

  // memory port and register map widths
  typedef logic [31:0] addr_t;     // byte address
  typedef logic [7:0]  data_t;     // one memory byte
  typedef logic [15:0] len_t;      // beats, beat index, error count

  // run sequencer states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    FILL   = 2'd1,
    VERIFY = 2'd2,
    DONE   = 2'd3
  } state_t;

  // host parameter bank entries
  localparam logic [2:0] PARAM_ADDR = 3'd1;  // start address
  localparam logic [2:0] PARAM_LEN  = 3'd2;  // length, low 16 bits
  localparam logic [2:0] PARAM_SEED = 3'd3;  // seed, low 8 bits

  // Galois feedback mask for x^8+x^6+x^5+x^4+1
  localparam data_t LFSR_TAPS = 8'hB8;

endpackage

//--- logic/param_bank.sv
`timescale 1ns/1ns

module param_bank import selfcheck_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        param_write,   // one-cycle host strobe
  input  logic [2:0]  param_index,
  input  logic [31:0] param_value,
  output addr_t       start_addr,
  output len_t        run_len,
  output data_t       seed
);

  always_ff @(posedge clk) begin
    if (reset) begin
      start_addr <= '0;
      run_len    <= '0;
      seed       <= '0;
    end else if (param_write) begin
      case (param_index)
        PARAM_ADDR: start_addr <= addr_t'(param_value);
        PARAM_LEN:  run_len    <= param_value[15:0];   // length field only
        PARAM_SEED: seed       <= param_value[7:0];    // seed byte only
        default: ;                                     // unused entries dropped
      endcase
    end
  end

endmodule

//--- logic/selfcheck_fsm.sv
`timescale 1ns/1ns

module selfcheck_fsm import selfcheck_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   start,
  input  len_t   run_len,
  input  logic   last_beat,
  input  logic   mem_waitrequest,
  output logic   mem_read,
  output logic   mem_write,
  output logic   cnt_clear,
  output logic   cnt_step,
  output logic   pat_load,
  output logic   pat_step,
  output logic   check_clear,
  output logic   check_en,
  output logic   processing,
  output logic   done,
  output state_t debug_state
);

  state_t state, next_state;
  logic   accept;                          // command taken this cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  assign accept = !mem_waitrequest;

  always_comb begin
    next_state  = state;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    cnt_clear   = 1'b0;
    cnt_step    = 1'b0;
    pat_load    = 1'b0;
    pat_step    = 1'b0;
    check_clear = 1'b0;
    check_en    = 1'b0;
    processing  = 1'b0;
    done        = 1'b0;

    case (state)
      IDLE, DONE: begin
        done = (state == DONE);        // holds until the next start
        if (start) begin
          processing  = 1'b1;
          check_clear = 1'b1;          // drop the previous result
          if (run_len == '0) begin
            next_state = DONE;         // nothing to touch
          end else begin
            next_state = FILL;
            cnt_clear  = 1'b1;
            pat_load   = 1'b1;
          end
        end
      end

      FILL: begin
        processing = 1'b1;
        mem_write  = 1'b1;
        if (accept) begin
          if (last_beat) begin
            // rewind index and pattern for the readback pass
            next_state = VERIFY;
            cnt_clear  = 1'b1;
            pat_load   = 1'b1;
          end else begin
            cnt_step = 1'b1;
            pat_step = 1'b1;
          end
        end
      end

      VERIFY: begin
        processing = 1'b1;
        mem_read   = 1'b1;
        if (accept) begin
          check_en = 1'b1;             // readdata valid this cycle
          if (last_beat) begin
            next_state = DONE;
          end else begin
            cnt_step = 1'b1;
            pat_step = 1'b1;
          end
        end
      end

      default: next_state = IDLE;
    endcase
  end

  assign debug_state = state;

endmodule

//--- logic/beat_counter.sv
`timescale 1ns/1ns

module beat_counter import selfcheck_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  logic  step,
  input  addr_t start_addr,
  input  len_t  run_len,
  output addr_t mem_address,
  output logic  last_beat
);

  len_t index;                            // current beat

  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
    end else if (clear) begin
      index <= '0;
    end else if (step) begin
      index <= index + len_t'(1);
    end
  end

  // address stays put while the index does, so it holds under waitrequest
  assign mem_address = start_addr + addr_t'(index);
  assign last_beat   = (index == run_len - len_t'(1));

endmodule

//--- logic/pattern_gen.sv
`timescale 1ns/1ns

module pattern_gen import selfcheck_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  load,
  input  logic  step,
  input  data_t seed,
  output data_t pattern
);

  data_t lfsr;

  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr <= 8'h01;
    end else if (load) begin
      lfsr <= (seed == '0) ? 8'h01 : seed;   // zero would lock up
    end else if (step) begin
      // Galois form: shift right, fold taps back in on a 1 out
      lfsr <= lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
  end

  assign pattern = lfsr;                     // write data and expected byte

endmodule

//--- logic/readback_checker.sv
`timescale 1ns/1ns

module readback_checker import selfcheck_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  logic  check_en,
  input  data_t mem_readdata,
  input  data_t expected,
  input  addr_t mem_address,
  output len_t  error_count,
  output addr_t first_err_addr
);

  logic mismatch;

  assign mismatch = check_en && (mem_readdata != expected);

  always_ff @(posedge clk) begin
    if (reset) begin
      error_count    <= '0;
      first_err_addr <= '0;
    end else if (clear) begin
      error_count    <= '0;               // new run
      first_err_addr <= '0;
    end else if (mismatch) begin
      error_count <= error_count + len_t'(1);
      if (error_count == '0) begin
        first_err_addr <= mem_address;    // only the first one
      end
    end
  end

endmodule

//--- logic/selfcheck_top.sv
`timescale 1ns/1ns

module selfcheck_top import selfcheck_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        param_write,
  input  logic [2:0]  param_index,
  input  logic [31:0] param_value,
  input  logic        start,
  output logic        processing,
  output logic        done,
  output len_t        error_count,
  output addr_t       first_err_addr,
  output state_t      debug_state,
  output addr_t       mem_address,
  output logic        mem_write,
  output data_t       mem_writedata,
  output logic        mem_read,
  input  logic        mem_waitrequest,
  input  data_t       mem_readdata
);

  addr_t start_addr;
  len_t  run_len;
  data_t seed;
  logic  last_beat;
  logic  cnt_clear, cnt_step;
  logic  pat_load, pat_step;
  logic  check_clear, check_en;

  param_bank u_param_bank (
    .clk         (clk),
    .reset       (reset),
    .param_write (param_write),
    .param_index (param_index),
    .param_value (param_value),
    .start_addr  (start_addr),
    .run_len     (run_len),
    .seed        (seed)
  );

  selfcheck_fsm u_fsm (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .run_len         (run_len),
    .last_beat       (last_beat),
    .mem_waitrequest (mem_waitrequest),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .cnt_clear       (cnt_clear),
    .cnt_step        (cnt_step),
    .pat_load        (pat_load),
    .pat_step        (pat_step),
    .check_clear     (check_clear),
    .check_en        (check_en),
    .processing      (processing),
    .done            (done),
    .debug_state     (debug_state)
  );

  beat_counter u_beat_counter (
    .clk         (clk),
    .reset       (reset),
    .clear       (cnt_clear),
    .step        (cnt_step),
    .start_addr  (start_addr),
    .run_len     (run_len),
    .mem_address (mem_address),
    .last_beat   (last_beat)
  );

  // pattern drives the write bus and is the expected readback byte
  pattern_gen u_pattern_gen (
    .clk     (clk),
    .reset   (reset),
    .load    (pat_load),
    .step    (pat_step),
    .seed    (seed),
    .pattern (mem_writedata)
  );

  readback_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .clear          (check_clear),
    .check_en       (check_en),
    .mem_readdata   (mem_readdata),
    .expected       (mem_writedata),
    .mem_address    (mem_address),
    .error_count    (error_count),
    .first_err_addr (first_err_addr)
  );

endmodule

//--- testbench/mem_model.sv
`timescale 1ns/1ns

module mem_model import selfcheck_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  bp_en,        // random back-pressure on
  input  logic  fault_en,
  input  addr_t fault_addr,
  input  addr_t address,
  input  logic  write,
  input  data_t writedata,
  input  logic  read,
  output logic  waitrequest,
  output data_t readdata
);

  data_t       mem [0:1023];    // low 10 address bits
  integer      wait_seed = 32'h4ac1;
  logic [31:0] rnd;

  always @(posedge clk) begin
    if (reset) begin
      waitrequest <= 1'b0;
    end else begin
      rnd = $random(wait_seed);
      waitrequest <= bp_en && rnd[0];   // stall about half the cycles
    end
  end

  always @(posedge clk) begin
    if (!reset && write && !waitrequest) begin
      // a stuck cell at fault_addr stores the inverted byte
      if (fault_en && address == fault_addr) begin
        mem[address[9:0]] <= ~writedata;
      end else begin
        mem[address[9:0]] <= writedata;
      end
    end
  end

  assign readdata = read ? mem[address[9:0]] : 8'h00;

endmodule

//--- testbench/tb_selfcheck.sv
`timescale 1ns/1ns

module tb_selfcheck import selfcheck_pkg::*; ();

  localparam int TIMEOUT = 2000;       // cycles allowed per run

  logic clk, reset, param_write, start, processing, done;
  logic [2:0] param_index;
  logic [31:0] param_value;
  len_t error_count;
  addr_t first_err_addr, mem_address, fault_addr;
  state_t debug_state;
  logic mem_write, mem_read, mem_waitrequest, bp_en, fault_en;
  data_t mem_writedata, mem_readdata;
  int cmd_count;
  logic held, held_write, held_read;   // last edge was a stalled command
  addr_t held_addr;
  data_t held_data;

  selfcheck_top DUT (.*);

  mem_model u_mem (
    .clk (clk), .reset (reset), .bp_en (bp_en), .fault_en (fault_en),
    .fault_addr (fault_addr), .address (mem_address), .write (mem_write),
    .writedata (mem_writedata), .read (mem_read),
    .waitrequest (mem_waitrequest), .readdata (mem_readdata)
  );

  always #5 clk = ~clk;

  task automatic fail_stop();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_len(input string name, input len_t got, input len_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_state(input string name, input state_t got, input state_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      fail_stop();
    end
  endtask

  // n-th byte of the Galois sequence, zero seed runs as 01
  function automatic data_t lfsr_byte(input data_t sd, input int n);
    data_t s;
    s = (sd == 8'h00) ? 8'h01 : sd;
    for (int k = 0; k < n; k++) begin
      s = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    end
    return s;
  endfunction

  function automatic data_t fill_byte(input logic [9:0] a);
    return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]};
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic write_param(input logic [2:0] idx, input logic [31:0] value);
    tick();
    param_write = 1'b1;
    param_index = idx;
    param_value = value;
    tick();
    param_write = 1'b0;
  endtask

  task automatic pulse_start();
    tick();
    start = 1'b1;
    #1;
    check_flag("processing", processing, 1'b1);   // combinational on start
    tick();
    start = 1'b0;
  endtask

  task automatic run_case(input addr_t base, input len_t len, input data_t sd,
                          input logic faulty, input addr_t faddr);
    int cycles;
    int exp_err;
    data_t exp;
    write_param(PARAM_ADDR, base);
    write_param(PARAM_LEN, {16'hbeef, len});     // upper bits ignored
    write_param(PARAM_SEED, {24'ha5a5a5, sd});
    for (int i = 0; i < 1024; i++) u_mem.mem[i] = fill_byte(10'(i));
    fault_en   = faulty;
    fault_addr = faddr;
    exp_err    = (faulty && faddr >= base && faddr < base + len) ? 1 : 0;
    pulse_start();
    cycles = 0;
    while (!done) begin
      check_flag("processing", processing, 1'b1);  // FILL or VERIFY
      tick();
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: done never rose after start");
        fail_stop();
      end
    end
    if (!bp_en) check_len("run cycles", len_t'(cycles), len_t'(2 * len));
    check_state("debug_state", debug_state, DONE);
    check_len("error_count", error_count, len_t'(exp_err));
    check_addr("first_err_addr", first_err_addr, (exp_err != 0) ? faddr : '0);
    for (int j = 0; j < 1024; j++) begin
      if (addr_t'(j) >= base && addr_t'(j) < base + len) begin
        exp = lfsr_byte(sd, j - int'(base));
        if (faulty && addr_t'(j) == faddr) exp = ~exp;
      end else begin
        exp = fill_byte(10'(j));                 // outside the range
      end
      check_data($sformatf("mem[%0d]", j), u_mem.mem[j], exp);
    end
    fault_en = 1'b0;
  endtask

  // address, data and command must hold across a stalled cycle
  always @(posedge clk) begin
    if (!reset && (mem_read || mem_write)) cmd_count++;
    if (!reset && held) begin
      check_addr("mem_address", mem_address, held_addr);
      check_data("mem_writedata", mem_writedata, held_data);
      check_flag("mem_write", mem_write, held_write);
      check_flag("mem_read", mem_read, held_read);
    end
    held       = !reset && mem_waitrequest && (mem_read || mem_write);
    held_addr  = mem_address;
    held_data  = mem_writedata;
    held_write = mem_write;
    held_read  = mem_read;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    param_write = 1'b0;
    param_index = '0;
    param_value = '0;
    start = 1'b0;
    bp_en = 1'b0;
    fault_en = 1'b0;
    fault_addr = '0;
    cmd_count = 0;
    held = 1'b0;
    repeat (8) tick();
    reset = 1'b0;

    run_case(32'd64, 16'd40, 8'h5a, 1'b0, '0);
    run_case(32'd64, 16'd40, 8'h5a, 1'b1, 32'd81);
    run_case(32'd64, 16'd40, 8'h00, 1'b0, '0);   // from DONE, stale count
    cmd_count = 0;
    run_case(32'd200, 16'd0, 8'h33, 1'b0, '0);
    check_len("command count", len_t'(cmd_count), '0);
    bp_en = 1'b1;
    run_case(32'd64, 16'd40, 8'hc3, 1'b0, '0);
    run_case(32'd64, 16'd40, 8'hc3, 1'b1, 32'd97);
    bp_en = 1'b0;

    write_param(PARAM_LEN, 32'd100);              // abort mid-run
    pulse_start();
    repeat (15) tick();
    check_flag("processing", processing, 1'b1);
    check_state("debug_state", debug_state, FILL);
    reset = 1'b1;
    repeat (8) tick();
    reset = 1'b0;
    check_flag("processing", processing, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("mem_read", mem_read, 1'b0);
    check_flag("mem_write", mem_write, 1'b0);
    check_state("debug_state", debug_state, IDLE);
    run_case(32'd300, 16'd25, 8'h81, 1'b1, 32'd310);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- sim.f
logic/selfcheck_pkg.sv
logic/param_bank.sv
logic/selfcheck_fsm.sv
logic/beat_counter.sv
logic/pattern_gen.sv
logic/readback_checker.sv
logic/selfcheck_top.sv
testbench/mem_model.sv
testbench/tb_selfcheck.sv

//--- Bender.yml
package:
  name: selfcheck

sources:
  - logic/selfcheck_pkg.sv
  - logic/param_bank.sv
  - logic/selfcheck_fsm.sv
  - logic/beat_counter.sv
  - logic/pattern_gen.sv
  - logic/readback_checker.sv
  - logic/selfcheck_top.sv
  - target: test
    files:
      - testbench/mem_model.sv
      - testbench/tb_selfcheck.sv
